/* verilog/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define XLEN 32

// general register file
`define REG_COUNT 32
`define REG_INDEX_W 5

// instruction word width
`define INST_W 32

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // core sequencer
    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY
    } core_state_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_IMM,
        ALU_LINK
    } alu_op_t;

    // what the instruction does after the alu
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH_EQ,
        CLS_BRANCH_NE,
        CLS_JAL,
        CLS_NOP
    } inst_class_t;

endpackage

`default_nettype wire

/* verilog/instr_fetch.sv */
`default_nettype none
`include "cpu_params.svh"

module instr_fetch (
    input  logic                inst_selfdefine,
    input  logic                reset,
    input  logic                if_ready,
    input  logic [`INST_W-1:0]  if_data,
    input  cpu_pkg::inst_class_t inst_class,
    input  logic                take_branch,
    input  logic [`XLEN-1:0]    target,
    input  logic                mem_done,
    output logic                if_valid,
    output logic [`XLEN-1:0]    if_addr,
    output logic [`INST_W-1:0]  inst,
    output logic [`XLEN-1:0]    pc,
    output logic                retire,
    output logic                mem_start
);
    import cpu_pkg::*;

    core_state_t state;
    logic        is_mem_class;
    logic [`XLEN-1:0] pc_next;

    assign is_mem_class = (inst_class == CLS_LOAD) || (inst_class == CLS_STORE);

    // one instruction in flight, so the bus address is simply the pc
    assign if_valid  = (state == FETCH);
    assign if_addr   = pc;
    assign mem_start = (state == MEMORY);

    assign retire = ((state == EXECUTE) && !is_mem_class) || ((state == MEMORY) && mem_done);

    // loads and stores never branch
    assign pc_next = take_branch ? target : pc + `XLEN'd4;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                FETCH: begin
                    if (if_ready) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_mem_class) begin
                        state <= MEMORY;
                    end else begin
                        state <= FETCH;
                        pc    <= pc_next;
                    end
                end
                MEMORY: begin
                    if (mem_done) begin
                        state <= FETCH;
                        pc    <= pc_next;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge inst_selfdefine) begin
        if (if_valid && if_ready) begin
            inst <= if_data;
        end
    end

    a_if_addr_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        (if_valid && !if_ready) |=> (if_valid && $stable(if_addr)));

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`default_nettype none
`include "cpu_params.svh"

module decoder (
    input  logic [`INST_W-1:0]      inst,
    output logic [`REG_INDEX_W-1:0] rs1_index,
    output logic [`REG_INDEX_W-1:0] rs2_index,
    output logic [`REG_INDEX_W-1:0] rd_index,
    output logic                    rd_en,
    output logic [`XLEN-1:0]        imm,
    output logic                    use_imm,
    output cpu_pkg::alu_op_t        alu_op,
    output cpu_pkg::inst_class_t    inst_class
);
    import cpu_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign rd_index  = inst[11:7];
    assign rs1_index = inst[19:15];
    assign rs2_index = inst[24:20];

    // sign-extended immediates, one per format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        alu_op     = ALU_ADD;
        inst_class = CLS_NOP;
        rd_en      = 1'b0;
        use_imm    = 1'b0;
        imm        = imm_i;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    inst_class = CLS_ALU;
                    rd_en      = 1'b1;
                    case (funct3)
                        3'b000: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                        3'b010: alu_op = ALU_SLT;
                        3'b100: alu_op = ALU_XOR;
                        3'b110: alu_op = ALU_OR;
                        3'b111: alu_op = ALU_AND;
                        default: begin
                            inst_class = CLS_NOP;
                            rd_en      = 1'b0;
                        end
                    endcase
                end
            end
            OPC_OP_IMM: begin
                inst_class = CLS_ALU;
                rd_en      = 1'b1;
                use_imm    = 1'b1;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: begin
                        inst_class = CLS_NOP;
                        rd_en      = 1'b0;
                    end
                endcase
            end
            OPC_LUI: begin
                inst_class = CLS_ALU;
                alu_op     = ALU_PASS_IMM;
                rd_en      = 1'b1;
                use_imm    = 1'b1;
                imm        = imm_u;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    inst_class = CLS_LOAD;
                    rd_en      = 1'b1;
                    use_imm    = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    inst_class = CLS_STORE;
                    use_imm    = 1'b1;
                    imm        = imm_s;
                end
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    inst_class = CLS_BRANCH_EQ;
                end else if (funct3 == 3'b001) begin
                    inst_class = CLS_BRANCH_NE;
                end
            end
            OPC_JAL: begin
                inst_class = CLS_JAL;
                alu_op     = ALU_LINK;
                rd_en      = 1'b1;
                imm        = imm_j;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none
`include "cpu_params.svh"

module alu (
    input  cpu_pkg::alu_op_t     alu_op,
    input  cpu_pkg::inst_class_t inst_class,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1_data,
    input  logic [`XLEN-1:0]     rs2_data,
    input  logic [`XLEN-1:0]     imm,
    input  logic                 use_imm,
    output logic [`XLEN-1:0]     result,
    output logic [`XLEN-1:0]     target,
    output logic                 take_branch
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] operand_b;

    assign operand_b = use_imm ? imm : rs2_data;

    always_comb begin
        if (inst_class == CLS_LOAD || inst_class == CLS_STORE) begin
            // effective address
            result = rs1_data + imm;
        end else begin
            case (alu_op)
                ALU_ADD:      result = rs1_data + operand_b;
                ALU_SUB:      result = rs1_data - operand_b;
                ALU_AND:      result = rs1_data & operand_b;
                ALU_OR:       result = rs1_data | operand_b;
                ALU_XOR:      result = rs1_data ^ operand_b;
                ALU_SLT:      result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
                ALU_PASS_IMM: result = imm;
                ALU_LINK:     result = pc + `XLEN'd4;
                default:      result = '0;
            endcase
        end
    end

    // jal and both branches are pc-relative
    assign target = pc + imm;

    always_comb begin
        case (inst_class)
            CLS_JAL:       take_branch = 1'b1;
            CLS_BRANCH_EQ: take_branch = (rs1_data == rs2_data);
            CLS_BRANCH_NE: take_branch = (rs1_data != rs2_data);
            default:       take_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none
`include "cpu_params.svh"

module regfile (
    input  logic                    inst_selfdefine,
    input  logic                    reset,
    input  logic [`REG_INDEX_W-1:0] rs1_index,
    input  logic [`REG_INDEX_W-1:0] rs2_index,
    input  logic [`REG_INDEX_W-1:0] rd_index,
    input  logic                    rd_en,
    input  logic                    retire,
    input  logic [`XLEN-1:0]        rd_data,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (retire && rd_en) begin
            regs[rd_index] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

/* verilog/load_store_unit.sv */
`default_nettype none
`include "cpu_params.svh"

module load_store_unit (
    input  logic                 inst_selfdefine,
    input  logic                 reset,
    input  cpu_pkg::inst_class_t inst_class,
    input  logic                 mem_start,
    input  logic [`XLEN-1:0]     alu_result,
    input  logic [`XLEN-1:0]     store_data,
    input  logic                 mem_ready,
    input  logic [`XLEN-1:0]     mem_rdata,
    output logic                 mem_valid,
    output logic                 mem_write,
    output logic [`XLEN-1:0]     mem_addr,
    output logic [`XLEN-1:0]     mem_wdata,
    output logic                 mem_done,
    output logic [`XLEN-1:0]     rd_data
);
    import cpu_pkg::*;

    // request held for the whole MEMORY state
    assign mem_valid = mem_start;
    assign mem_write = (inst_class == CLS_STORE);
    assign mem_addr  = alu_result;
    assign mem_wdata = store_data;
    assign mem_done  = mem_valid && mem_ready;

    // writeback select
    assign rd_data = (inst_class == CLS_LOAD) ? mem_rdata : alu_result;

    a_mem_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        (mem_valid && !mem_ready) |=>
            (mem_valid && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_write)));

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`default_nettype none
`include "cpu_params.svh"

module cpu_core (
    input  logic               inst_selfdefine,
    input  logic               reset,
    output logic               if_valid,
    input  logic               if_ready,
    output logic [`XLEN-1:0]   if_addr,
    input  logic [`INST_W-1:0] if_data,
    output logic               mem_valid,
    input  logic               mem_ready,
    output logic               mem_write,
    output logic [`XLEN-1:0]   mem_addr,
    output logic [`XLEN-1:0]   mem_wdata,
    input  logic [`XLEN-1:0]   mem_rdata
);
    import cpu_pkg::*;

    logic [`INST_W-1:0]      inst;
    logic [`XLEN-1:0]        pc;
    logic                    retire;
    logic                    mem_start;
    logic [`REG_INDEX_W-1:0] rs1_index;
    logic [`REG_INDEX_W-1:0] rs2_index;
    logic [`REG_INDEX_W-1:0] rd_index;
    logic                    rd_en;
    logic [`XLEN-1:0]        imm;
    logic                    use_imm;
    alu_op_t                 alu_op;
    inst_class_t             inst_class;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic [`XLEN-1:0]        result;
    logic [`XLEN-1:0]        target;
    logic                    take_branch;
    logic                    mem_done;
    logic [`XLEN-1:0]        rd_data;

    instr_fetch u_instr_fetch (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data         (if_data),
        .inst_class      (inst_class),
        .take_branch     (take_branch),
        .target          (target),
        .mem_done        (mem_done),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .inst            (inst),
        .pc              (pc),
        .retire          (retire),
        .mem_start       (mem_start)
    );

    decoder u_decoder (
        .inst       (inst),
        .rs1_index  (rs1_index),
        .rs2_index  (rs2_index),
        .rd_index   (rd_index),
        .rd_en      (rd_en),
        .imm        (imm),
        .use_imm    (use_imm),
        .alu_op     (alu_op),
        .inst_class (inst_class)
    );

    alu u_alu (
        .alu_op      (alu_op),
        .inst_class  (inst_class),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .use_imm     (use_imm),
        .result      (result),
        .target      (target),
        .take_branch (take_branch)
    );

    regfile u_regfile (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1_index       (rs1_index),
        .rs2_index       (rs2_index),
        .rd_index        (rd_index),
        .rd_en           (rd_en),
        .retire          (retire),
        .rd_data         (rd_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    load_store_unit u_load_store_unit (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .inst_class      (inst_class),
        .mem_start       (mem_start),
        .alu_result      (result),
        .store_data      (rs2_data),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_done        (mem_done),
        .rd_data         (rd_data)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic inst_selfdefine,
    output logic reset
);

    initial begin
        inst_selfdefine = 1'b0;
        forever #20 inst_selfdefine = ~inst_selfdefine;
    end

    // held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge inst_selfdefine);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* bench/tb_cpu_core.sv */
`default_nettype none
`include "cpu_params.svh"

module tb_cpu_core;

    localparam int PROG_DEPTH     = 64;
    localparam int TIMEOUT_CYCLES = PROG_DEPTH * (3 + 2 * 3);
    localparam int OPC_IMM        = 'h13;
    localparam int OPC_LOAD       = 'h03;
    // jal x0, 0
    localparam logic [`INST_W-1:0] JAL_SELF = 32'h0000_006F;

    logic                inst_selfdefine;
    logic                reset;
    logic                if_valid;
    logic                if_ready = 1'b0;
    logic [`XLEN-1:0]    if_addr;
    logic [`INST_W-1:0]  if_data;
    logic                mem_valid;
    logic                mem_ready = 1'b0;
    logic                mem_write;
    logic [`XLEN-1:0]    mem_addr;
    logic [`XLEN-1:0]    mem_wdata;
    logic [`XLEN-1:0]    mem_rdata;

    logic [`INST_W-1:0]  prog [0:PROG_DEPTH-1];
    int                  prog_len = 0;
    logic [`XLEN-1:0]    data_mem [0:63];
    logic [`XLEN-1:0]    exp_addr [0:31];
    logic [`XLEN-1:0]    exp_data [0:31];
    int                  exp_test [0:31];
    int                  store_count = 0;
    int                  store_idx = 0;
    int                  test_errors [1:5];
    string               test_name [1:5];
    int                  tests_ok = 0;
    int                  tests_bad = 0;
    int                  total_errors = 0;
    int                  cycle_count = 0;
    int                  seed = 2;
    logic [1:0]          if_wait = 2'd0;
    logic [1:0]          mem_wait = 2'd0;
    logic                if_ready_next = 1'b0;
    logic                mem_ready_next = 1'b0;
    logic                if_stalled = 1'b0;
    logic                mem_stalled = 1'b0;
    logic [`XLEN-1:0]    held_if_addr;
    logic [`XLEN-1:0]    held_mem_addr;
    logic [`XLEN-1:0]    held_mem_wdata;
    logic                held_mem_write;
    logic [`XLEN-1:0]    jal_pc;

    tb_clock clock_gen (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset)
    );

    cpu_core DUT (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_valid        (if_valid),
        .if_ready        (if_ready),
        .if_addr         (if_addr),
        .if_data         (if_data),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata)
    );

    // RV32 instruction formats
    function automatic logic [`INST_W-1:0] enc_r(input int f7, input int rs2, input int rs1,
                                                 input int f3, input int rd);
        enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [`INST_W-1:0] enc_i(input int imm, input int rs1, input int f3,
                                                 input int rd, input int opc);
        enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [`INST_W-1:0] enc_s(input int imm, input int rs2, input int rs1);
        enc_s = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [`INST_W-1:0] enc_b(input int imm, input int rs2, input int rs1,
                                                 input int f3);
        enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                 7'b1100011};
    endfunction

    function automatic logic [`INST_W-1:0] enc_u(input int imm, input int rd);
        enc_u = {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [`INST_W-1:0] enc_j(input int imm, input int rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic put_inst(input logic [`INST_W-1:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_store(input int tid, input logic [`XLEN-1:0] addr,
                                input logic [`XLEN-1:0] data);
        exp_test[store_count] = tid;
        exp_addr[store_count] = addr;
        exp_data[store_count] = data;
        store_count++;
    endtask

    task automatic report_mismatch(input int tid, input string name,
                                   input logic [`XLEN-1:0] expected,
                                   input logic [`XLEN-1:0] actual);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
        test_errors[tid]++;
    endtask

    task automatic report_test(input int tid);
        if (test_errors[tid] == 0) begin
            $display("[test %0d] %s: ok", tid, test_name[tid]);
            tests_ok++;
        end else begin
            $display("[test %0d] %s: %0d error(s)", tid, test_name[tid], test_errors[tid]);
            tests_bad++;
        end
    endtask

    task automatic check_store();
        int tid;
        if (store_idx >= store_count) begin
            $display("unexpected store of %h to address %h at %0t after the last expected one",
                     mem_wdata, mem_addr, $time);
            test_errors[5]++;
        end else begin
            tid = exp_test[store_idx];
            if (mem_addr !== exp_addr[store_idx]) begin
                report_mismatch(tid, "mem_addr", exp_addr[store_idx], mem_addr);
            end
            if (mem_wdata !== exp_data[store_idx]) begin
                report_mismatch(tid, "mem_wdata", exp_data[store_idx], mem_wdata);
            end
            store_idx++;
            if (store_idx == store_count || exp_test[store_idx] != tid) begin
                report_test(tid);
            end
        end
    endtask

    // 0 to 3 wait cycles per request
    task automatic pace_ready(input logic valid, input logic ready,
                              inout logic [1:0] wait_left, inout logic ready_next);
        logic [31:0] rnd;
        if (valid && !ready) begin
            if (wait_left == 2'd0) begin
                ready_next = 1'b1;
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end else begin
            rnd = $random(seed);
            ready_next = (rnd[1:0] == 2'd0);
            wait_left = rnd[1:0] - 2'd1;
        end
    endtask

    // instruction memory, jal-to-self past the program
    always_comb begin
        if (if_addr < prog_len * 4) begin
            if_data = prog[if_addr[7:2]];
        end else begin
            if_data = JAL_SELF;
        end
    end

    always_comb begin
        if (mem_addr[31:8] == 24'd0) begin
            mem_rdata = data_mem[mem_addr[7:2]];
        end else begin
            mem_rdata = mem_addr ^ 32'h5A5A_5A5A;
        end
    end

    always @(posedge inst_selfdefine) begin
        if (reset) begin
            if_ready  <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            if_ready  <= if_ready_next;
            mem_ready <= mem_ready_next;
        end
    end

    // monitor, on the falling edge where bus signals are settled
    always @(negedge inst_selfdefine) begin
        if (reset) begin
            if_ready_next  = 1'b0;
            mem_ready_next = 1'b0;
            if_stalled     = 1'b0;
            mem_stalled    = 1'b0;
        end else begin
            cycle_count++;
            if (if_stalled) begin
                if (!if_valid) begin
                    $display("if_valid dropped at %0t before if_ready was given", $time);
                    test_errors[5]++;
                end else if (if_addr !== held_if_addr) begin
                    report_mismatch(5, "if_addr", held_if_addr, if_addr);
                end
            end
            if (mem_stalled) begin
                if (!mem_valid) begin
                    $display("mem_valid dropped at %0t before mem_ready was given", $time);
                    test_errors[5]++;
                end else begin
                    if (mem_addr !== held_mem_addr) begin
                        report_mismatch(5, "mem_addr", held_mem_addr, mem_addr);
                    end
                    if (mem_wdata !== held_mem_wdata) begin
                        report_mismatch(5, "mem_wdata", held_mem_wdata, mem_wdata);
                    end
                    if (mem_write !== held_mem_write) begin
                        report_mismatch(5, "mem_write", {31'b0, held_mem_write},
                                        {31'b0, mem_write});
                    end
                end
            end
            if (mem_valid && mem_ready && mem_write) begin
                check_store();
            end
            pace_ready(if_valid, if_ready, if_wait, if_ready_next);
            pace_ready(mem_valid, mem_ready, mem_wait, mem_ready_next);
            if_stalled     = if_valid && !if_ready;
            held_if_addr   = if_addr;
            mem_stalled    = mem_valid && !mem_ready;
            held_mem_addr  = mem_addr;
            held_mem_wdata = mem_wdata;
            held_mem_write = mem_write;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(negedge inst_selfdefine);
        end
        $display("timeout after %0d cycles, %0d of %0d expected stores seen",
                 cycle_count, store_idx, store_count);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [`XLEN-1:0] fill_addr;
        test_name[1] = "register and immediate arithmetic";
        test_name[2] = "loads then add";
        test_name[3] = "branches and jal";
        test_name[4] = "writes to x0";
        test_name[5] = "bus handshake under wait states";
        for (int t = 1; t <= 5; t++) begin
            test_errors[t] = 0;
        end
        for (int i = 0; i < 64; i++) begin
            fill_addr = i * 4;
            data_mem[i] = {fill_addr[15:0], ~fill_addr[15:0]};
        end
        data_mem[16] = 32'h1234_0001;
        data_mem[17] = 32'h0000_FFFF;

        // test 1
        put_inst(enc_i(90, 0, 0, 1, OPC_IMM));
        put_inst(enc_i(-7, 0, 0, 2, OPC_IMM));
        put_inst(enc_r(0, 2, 1, 0, 3));
        put_inst(enc_r(32, 2, 1, 0, 4));
        put_inst(enc_r(0, 2, 1, 7, 5));
        put_inst(enc_r(0, 2, 1, 6, 6));
        put_inst(enc_r(0, 2, 1, 4, 7));
        put_inst(enc_r(0, 1, 2, 2, 8));
        put_inst(enc_r(0, 2, 1, 2, 9));
        put_inst(enc_i(15, 1, 7, 10, OPC_IMM));
        put_inst(enc_i(256, 1, 6, 11, OPC_IMM));
        put_inst(enc_i(-1, 1, 4, 12, OPC_IMM));
        put_inst(enc_u(32'h12345, 13));
        put_inst(enc_i(32'h678, 13, 0, 13, OPC_IMM));
        // sw x3..x13 to 0x200 upwards
        for (int r = 3; r <= 13; r++) begin
            put_inst(enc_s((r - 3) * 4 + 32'h200, r, 0));
        end
        expect_store(1, 32'h200, 32'h0000_0053);
        expect_store(1, 32'h204, 32'h0000_0061);
        expect_store(1, 32'h208, 32'h0000_0058);
        expect_store(1, 32'h20C, 32'hFFFF_FFFB);
        expect_store(1, 32'h210, 32'hFFFF_FFA3);
        expect_store(1, 32'h214, 32'h0000_0001);
        expect_store(1, 32'h218, 32'h0000_0000);
        expect_store(1, 32'h21C, 32'h0000_000A);
        expect_store(1, 32'h220, 32'h0000_015A);
        expect_store(1, 32'h224, 32'hFFFF_FFA5);
        expect_store(1, 32'h228, 32'h1234_5678);

        // test 2
        put_inst(enc_i(32'h40, 0, 2, 14, OPC_LOAD));
        put_inst(enc_i(32'h44, 0, 2, 15, OPC_LOAD));
        put_inst(enc_r(0, 15, 14, 0, 16));
        put_inst(enc_s(32'h240, 16, 0));
        put_inst(enc_i(32'h40, 0, 0, 17, OPC_IMM));
        put_inst(enc_i(4, 17, 2, 18, OPC_LOAD));
        put_inst(enc_s(32'h244, 18, 0));
        put_inst(enc_i(32'h80, 0, 2, 19, OPC_LOAD));
        put_inst(enc_s(32'h248, 19, 0));
        expect_store(2, 32'h240, 32'h1235_0000);
        expect_store(2, 32'h244, 32'h0000_FFFF);
        expect_store(2, 32'h248, 32'h0080_FF7F);

        // test 3, stores to 0x2F0 and above must never show up
        put_inst(enc_i(5, 0, 0, 20, OPC_IMM));
        put_inst(enc_i(5, 0, 0, 21, OPC_IMM));
        put_inst(enc_b(12, 21, 20, 0));
        put_inst(enc_s(32'h2F0, 20, 0));
        put_inst(enc_s(32'h2F4, 21, 0));
        put_inst(enc_b(8, 21, 20, 1));
        put_inst(enc_i(32'h33, 0, 0, 22, OPC_IMM));
        put_inst(enc_b(8, 20, 22, 1));
        put_inst(enc_i(32'h77, 0, 0, 22, OPC_IMM));
        put_inst(enc_b(8, 20, 22, 0));
        put_inst(enc_s(32'h280, 22, 0));
        jal_pc = prog_len * 4;
        put_inst(enc_j(8, 23));
        put_inst(enc_s(32'h2F8, 20, 0));
        put_inst(enc_s(32'h284, 23, 0));
        expect_store(3, 32'h280, 32'h0000_0033);
        expect_store(3, 32'h284, jal_pc + 4);

        // test 4
        put_inst(enc_i(32'h55, 0, 0, 0, OPC_IMM));
        put_inst(enc_r(0, 1, 1, 0, 0));
        put_inst(enc_s(32'h2A0, 0, 0));
        expect_store(4, 32'h2A0, 32'h0000_0000);

        while (store_idx < store_count) begin
            @(negedge inst_selfdefine);
        end
        // let any stray store show up
        repeat (20) @(negedge inst_selfdefine);
        report_test(5);
        for (int t = 1; t <= 5; t++) begin
            total_errors += test_errors[t];
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, total_errors);
        if (total_errors == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/instr_fetch.sv
verilog/decoder.sv
verilog/alu.sv
verilog/regfile.sv
verilog/load_store_unit.sv
verilog/cpu_core.sv
bench/tb_clock.sv
bench/tb_cpu_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

# build the simulation with assertions enabled
verilator --binary --timing --assert -f flist.f --top-module tb_cpu_core -o sim_cpu_core

# run it and keep the output for the search below
out=$(./obj_dir/sim_cpu_core)
printf '%s\n' "$out"

# the exit status comes from this search
printf '%s\n' "$out" | grep -qx "test passed"
